//--- include/txMux_defs.svh
`ifndef TXMUX_DEFS_SVH
`define TXMUX_DEFS_SVH

// Channel side
`define TXM_NUM_CHNL        4
`define TXM_CHNL_W          2
`define TXM_SG_W            2     // Scatter-gather list selector

// Request fields
`define TXM_ADDR_W          32
`define TXM_LEN_W           10    // Counted in 32-bit words
`define TXM_TAG_W           5

// Data path
`define TXM_DATA_W          128
`define TXM_DW_PER_BEAT     4
`define TXM_OFFSET_W        2
`define TXM_FIFO_LATENCY    3     // Read enable to valid channel data

// Request type codes in the metadata
`define TXM_REQ_RD          1'b0
`define TXM_REQ_WR          1'b1

`endif

//--- logic/burstSequencer.sv
`default_nettype none

`include "txMux_defs.svh"

module burstSequencer (
    input  logic                        CLK,
    input  logic                        reset,
    input  logic                        capValid,
    input  logic                        capIsWr,
    input  logic [`TXM_CHNL_W-1:0]      capChnl,
    input  logic [`TXM_ADDR_W-1:0]      capAddr,
    input  logic [`TXM_LEN_W-1:0]       capLen,
    input  logic [`TXM_TAG_W-1:0]       capTag,
    input  logic                        metaReady,
    output logic                        capTaken,
    output txMuxPkg::txMeta_t           meta,
    output logic                        metaValid,
    output logic [`TXM_NUM_CHNL-1:0]    wrDataRen,
    output logic                        beatValid,
    output logic [`TXM_CHNL_W-1:0]      beatChnl,
    output logic                        beatStart,
    output logic                        beatEnd,
    output logic [`TXM_OFFSET_W-1:0]    beatEndOffset
);

    localparam logic [`TXM_LEN_W-1:0] wordsPerBeat    = `TXM_DW_PER_BEAT;
    localparam logic [`TXM_LEN_W-1:0] wordsPerTwoBeat = 2 * `TXM_DW_PER_BEAT;

    typedef enum logic {stIdle, stWrite} seqState_t;

    seqState_t              state;
    logic                   issue;
    logic [`TXM_LEN_W-1:0]  remain;      // Words left, including the current beat

    assign issue     = (state == stIdle) && capValid && metaReady;
    assign capTaken  = issue;
    assign metaValid = issue;

    // ------------------------------------------------------------
    // Metadata word, straight from the captured record
    // ------------------------------------------------------------
    always_comb begin
        meta.reqType = capIsWr ? `TXM_REQ_WR : `TXM_REQ_RD;
        meta.addr    = capAddr;
        meta.len     = capLen;
        meta.tag     = capTag;
        meta.firstBe = '1;
        meta.lastBe  = (capLen == 1) ? 4'b0000 : 4'b1111;  // Single-word request
    end

    // ------------------------------------------------------------
    // Beat counting, one FIFO read per beat
    // ------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (reset) begin
            state     <= stIdle;
            beatValid <= 1'b0;
            wrDataRen <= '0;
        end else begin
            beatValid <= 1'b0;
            wrDataRen <= '0;
            if (state == stIdle) begin
                if (issue && capIsWr) begin
                    beatValid          <= 1'b1;
                    wrDataRen[capChnl] <= 1'b1;
                    if (capLen > wordsPerBeat)
                        state <= stWrite;
                end
            end else begin
                beatValid           <= 1'b1;
                wrDataRen[beatChnl] <= 1'b1;
                if (remain <= wordsPerTwoBeat)
                    state <= stIdle;   // This is the last beat
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == stIdle) begin
            remain        <= capLen;
            beatChnl      <= capChnl;
            beatStart     <= 1'b1;
            beatEnd       <= (capLen <= wordsPerBeat);
            beatEndOffset <= capLen[`TXM_OFFSET_W-1:0] - 1'b1;
        end else begin
            remain    <= remain - wordsPerBeat;
            beatStart <= 1'b0;
            beatEnd   <= (remain <= wordsPerTwoBeat);
        end
    end

endmodule

`default_nettype wire

//--- logic/dataDelayLine.sv
`default_nettype none

`include "txMux_defs.svh"

module dataDelayLine (
    input  logic                                       CLK,
    input  logic                                       reset,
    input  logic                                       beatValid,
    input  logic [`TXM_CHNL_W-1:0]                     beatChnl,
    input  logic                                       beatStart,
    input  logic                                       beatEnd,
    input  logic [`TXM_OFFSET_W-1:0]                   beatEndOffset,
    input  logic [`TXM_NUM_CHNL-1:0][`TXM_DATA_W-1:0]  wrDataAll,
    output txMuxPkg::dataBeat_t                        beat,
    output logic                                       dataValid
);

    typedef struct packed {
        logic                     valid;
        logic [`TXM_CHNL_W-1:0]   chnl;
        logic                     startFlag;
        logic                     endFlag;
        logic [`TXM_OFFSET_W-1:0] endOffset;
    } beatCtrl_t;

    beatCtrl_t                          inCtrl;
    beatCtrl_t [`TXM_FIFO_LATENCY:0]    pipe;       // Stage k is k+1 cycles old
    logic [`TXM_DATA_W-1:0]             beatData;

    assign inCtrl = {beatValid, beatChnl, beatStart, beatEnd, beatEndOffset};

    always_ff @(posedge CLK) begin
        if (reset)
            pipe <= '0;
        else
            pipe <= {pipe[`TXM_FIFO_LATENCY-1:0], inCtrl};
    end

    // Channel word is valid when its control reaches this stage
    always_ff @(posedge CLK) begin
        beatData <= wrDataAll[pipe[`TXM_FIFO_LATENCY-1].chnl];
    end

    always_comb begin
        beat.data      = beatData;
        beat.startFlag = pipe[`TXM_FIFO_LATENCY].startFlag & pipe[`TXM_FIFO_LATENCY].valid;
        beat.endFlag   = pipe[`TXM_FIFO_LATENCY].endFlag & pipe[`TXM_FIFO_LATENCY].valid;
        beat.endOffset = pipe[`TXM_FIFO_LATENCY].endOffset;
    end

    assign dataValid = pipe[`TXM_FIFO_LATENCY].valid;

endmodule

`default_nettype wire

//--- logic/requestCapture.sv
`default_nettype none

`include "txMux_defs.svh"

module requestCapture (
    input  logic                             CLK,
    input  logic                             reset,
    input  logic                             rdPending,
    input  logic [`TXM_CHNL_W-1:0]           rdChnl,
    input  txMuxPkg::rdReq_t                 rdReq,
    input  logic                             wrPending,
    input  logic [`TXM_CHNL_W-1:0]           wrChnl,
    input  txMuxPkg::wrReq_t                 wrReq,
    input  logic [`TXM_TAG_W-1:0]            extTag,
    input  logic                             extTagValid,
    input  logic                             rxBufSpaceAvail,
    input  logic                             capTaken,
    output logic [`TXM_NUM_CHNL-1:0]         rdAck,
    output logic [`TXM_NUM_CHNL-1:0]         wrAck,
    output logic [`TXM_SG_W+`TXM_CHNL_W-1:0] intTag,
    output logic                             intTagValid,
    output logic                             rdReqSent,
    output logic                             rdHold,
    output logic                             wrHold,
    output logic                             capValid,
    output logic                             capIsWr,
    output logic [`TXM_CHNL_W-1:0]           capChnl,
    output logic [`TXM_ADDR_W-1:0]           capAddr,
    output logic [`TXM_LEN_W-1:0]            capLen,
    output logic [`TXM_TAG_W-1:0]            capTag
);

    typedef enum logic [1:0] {
        stRdCheck,
        stWrCheck,
        stCapture,
        stRelease
    } capState_t;

    capState_t state;
    logic      isWr;     // Side acknowledged last
    logic      rdGo;

    // A read needs a free external tag and room for the completion
    assign rdGo = rdPending && extTagValid && rxBufSpaceAvail;

    // Selectors keep their choice from the decision cycle through capture
    assign rdHold = (state == stRdCheck && rdGo) || (state == stCapture && !isWr);
    assign wrHold = (state == stWrCheck && wrPending) || (state == stCapture && isWr);

    assign intTag   = {rdReq.sgSel, rdChnl};
    assign capValid = (state == stRelease);

    always_ff @(posedge CLK) begin
        if (reset) begin
            state       <= stRdCheck;
            isWr        <= 1'b0;
            rdAck       <= '0;
            wrAck       <= '0;
            intTagValid <= 1'b0;
            rdReqSent   <= 1'b0;
        end else begin
            rdAck       <= '0;       // Acknowledges are single-cycle pulses
            wrAck       <= '0;
            intTagValid <= 1'b0;
            rdReqSent   <= 1'b0;
            case (state)
                stRdCheck: begin
                    if (rdGo) begin
                        rdAck[rdChnl] <= 1'b1;
                        intTagValid   <= 1'b1;
                        rdReqSent     <= 1'b1;
                        isWr          <= 1'b0;
                        state         <= stCapture;
                    end else begin
                        state <= stWrCheck;
                    end
                end
                stWrCheck: begin
                    if (wrPending) begin
                        wrAck[wrChnl] <= 1'b1;
                        isWr          <= 1'b1;
                        state         <= stCapture;
                    end else begin
                        state <= stRdCheck;
                    end
                end
                stCapture: state <= stRelease;
                stRelease: if (capTaken) state <= isWr ? stRdCheck : stWrCheck;
                default:   state <= stRdCheck;
            endcase
        end
    end

    // Record latch, extTag answers the tag exchange of the previous cycle
    always_ff @(posedge CLK) begin
        if (state == stCapture) begin
            capIsWr <= isWr;
            capChnl <= isWr ? wrChnl : rdChnl;
            capAddr <= isWr ? wrReq.addr : rdReq.addr;
            capLen  <= isWr ? wrReq.len : rdReq.len;
            capTag  <= extTag ^ {isWr, {(`TXM_TAG_W-1){1'b0}}};
        end
    end

endmodule

`default_nettype wire

//--- logic/roundRobinSelector.sv
`default_nettype none

`include "txMux_defs.svh"

module roundRobinSelector #(
    parameter type payload_t = logic [`TXM_ADDR_W-1:0]
) (
    input  logic                           CLK,
    input  logic                           reset,
    input  logic [`TXM_NUM_CHNL-1:0]       reqAll,
    input  payload_t [`TXM_NUM_CHNL-1:0]   payloadAll,
    input  logic                           hold,        // Choice taken by the capture stage
    output logic                           reqValid,
    output logic [`TXM_CHNL_W-1:0]         chnl,
    output payload_t                       payload
);

    logic [`TXM_CHNL_W-1:0] lastGrant;
    logic [`TXM_CHNL_W-1:0] winner;
    logic                   found;

    // Search starts just after the last channel that was taken
    always_comb begin
        logic [`TXM_CHNL_W-1:0] idx;
        winner = lastGrant;
        found  = 1'b0;
        for (int i = 1; i <= `TXM_NUM_CHNL; i++) begin
            idx = lastGrant + i[`TXM_CHNL_W-1:0];
            if (!found && reqAll[idx]) begin
                found  = 1'b1;
                winner = idx;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            reqValid  <= 1'b0;
            chnl      <= '0;
            lastGrant <= '1;                 // Channel 0 goes first
        end else if (hold) begin
            lastGrant <= chnl;
        end else begin
            reqValid <= found;
            chnl     <= winner;
        end
    end

    always_ff @(posedge CLK) begin
        if (!hold)
            payload <= payloadAll[winner];
    end

endmodule

`default_nettype wire

//--- logic/txMultiplexer.sv
`default_nettype none

`include "txMux_defs.svh"

module txMultiplexer (
    input  logic                                       CLK,
    input  logic                                       reset,
    // Channel requests
    input  logic [`TXM_NUM_CHNL-1:0]                   rdReq,
    input  txMuxPkg::rdReq_t [`TXM_NUM_CHNL-1:0]       rdInfo,
    output logic [`TXM_NUM_CHNL-1:0]                   rdAck,
    input  logic [`TXM_NUM_CHNL-1:0]                   wrReq,
    input  txMuxPkg::wrReq_t [`TXM_NUM_CHNL-1:0]       wrInfo,
    output logic [`TXM_NUM_CHNL-1:0]                   wrAck,
    input  logic [`TXM_NUM_CHNL-1:0][`TXM_DATA_W-1:0]  wrData,
    output logic [`TXM_NUM_CHNL-1:0]                   wrDataRen,
    // Tag exchange and receive buffer
    output logic [`TXM_SG_W+`TXM_CHNL_W-1:0]           intTag,
    output logic                                       intTagValid,
    input  logic [`TXM_TAG_W-1:0]                      extTag,
    input  logic                                       extTagValid,
    output logic                                       rdReqSent,
    input  logic                                       rxBufSpaceAvail,
    // Formatter side
    output txMuxPkg::txMeta_t                          meta,
    output logic                                       metaValid,
    input  logic                                       metaReady,
    output txMuxPkg::dataBeat_t                        beat,
    output logic                                       dataValid
);

    import txMuxPkg::*;

    logic                       rdPending, wrPending, rdHold, wrHold;
    logic [`TXM_CHNL_W-1:0]     rdChnl, wrChnl;
    rdReq_t                     rdSel;
    wrReq_t                     wrSel;

    logic                       capValid, capIsWr, capTaken;
    logic [`TXM_CHNL_W-1:0]     capChnl;
    logic [`TXM_ADDR_W-1:0]     capAddr;
    logic [`TXM_LEN_W-1:0]      capLen;
    logic [`TXM_TAG_W-1:0]      capTag;

    logic                       beatValid, beatStart, beatEnd;
    logic [`TXM_CHNL_W-1:0]     beatChnl;
    logic [`TXM_OFFSET_W-1:0]   beatEndOffset;

    // ------------------------------------------------------------
    // Channel selection, one arbiter per side
    // ------------------------------------------------------------
    roundRobinSelector #(.payload_t(rdReq_t)) rdSelector (
        .CLK(CLK), .reset(reset), .reqAll(rdReq), .payloadAll(rdInfo), .hold(rdHold),
        .reqValid(rdPending), .chnl(rdChnl), .payload(rdSel)
    );

    roundRobinSelector #(.payload_t(wrReq_t)) wrSelector (
        .CLK(CLK), .reset(reset), .reqAll(wrReq), .payloadAll(wrInfo), .hold(wrHold),
        .reqValid(wrPending), .chnl(wrChnl), .payload(wrSel)
    );

    requestCapture capture (
        .CLK(CLK), .reset(reset),
        .rdPending(rdPending), .rdChnl(rdChnl), .rdReq(rdSel),
        .wrPending(wrPending), .wrChnl(wrChnl), .wrReq(wrSel),
        .extTag(extTag), .extTagValid(extTagValid), .rxBufSpaceAvail(rxBufSpaceAvail),
        .capTaken(capTaken), .rdAck(rdAck), .wrAck(wrAck),
        .intTag(intTag), .intTagValid(intTagValid), .rdReqSent(rdReqSent),
        .rdHold(rdHold), .wrHold(wrHold), .capValid(capValid), .capIsWr(capIsWr),
        .capChnl(capChnl), .capAddr(capAddr), .capLen(capLen), .capTag(capTag)
    );

    // ------------------------------------------------------------
    // Metadata issue and write data path
    // ------------------------------------------------------------
    burstSequencer sequencer (
        .CLK(CLK), .reset(reset), .capValid(capValid), .capIsWr(capIsWr),
        .capChnl(capChnl), .capAddr(capAddr), .capLen(capLen), .capTag(capTag),
        .metaReady(metaReady), .capTaken(capTaken), .meta(meta), .metaValid(metaValid),
        .wrDataRen(wrDataRen), .beatValid(beatValid), .beatChnl(beatChnl),
        .beatStart(beatStart), .beatEnd(beatEnd), .beatEndOffset(beatEndOffset)
    );

    dataDelayLine delayLine (
        .CLK(CLK), .reset(reset), .beatValid(beatValid), .beatChnl(beatChnl),
        .beatStart(beatStart), .beatEnd(beatEnd), .beatEndOffset(beatEndOffset),
        .wrDataAll(wrData), .beat(beat), .dataValid(dataValid)
    );

endmodule

`default_nettype wire

//--- logic/txMuxPkg.sv
`default_nettype none

`include "txMux_defs.svh"

package txMuxPkg;

    // Per-channel read request payload
    typedef struct packed {
        logic [`TXM_ADDR_W-1:0] addr;
        logic [`TXM_LEN_W-1:0]  len;
        logic [`TXM_SG_W-1:0]   sgSel;
    } rdReq_t;

    typedef struct packed {
        logic [`TXM_ADDR_W-1:0] addr;
        logic [`TXM_LEN_W-1:0]  len;
    } wrReq_t;

    // One word per accepted request, to the formatter
    typedef struct packed {
        logic                   reqType;
        logic [`TXM_ADDR_W-1:0] addr;
        logic [`TXM_LEN_W-1:0]  len;
        logic [`TXM_TAG_W-1:0]  tag;
        logic [3:0]             firstBe;
        logic [3:0]             lastBe;
    } txMeta_t;

    typedef struct packed {
        logic [`TXM_DATA_W-1:0]   data;
        logic                     startFlag;
        logic                     endFlag;
        logic [`TXM_OFFSET_W-1:0] endOffset;   // Last valid word in the end beat
    } dataBeat_t;

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module txMultiplexerTb \
    -o simTb && ./obj_dir/simTb || exit 1

//--- sources.f
+incdir+include
logic/txMuxPkg.sv
logic/roundRobinSelector.sv
logic/requestCapture.sv
logic/burstSequencer.sv
logic/dataDelayLine.sv
logic/txMultiplexer.sv
tb/txMultiplexer_checker.sv
tb/txMultiplexerTb.sv

//--- tb/txMultiplexerTb.sv
`default_nettype none

`include "txMux_defs.svh"

module txMultiplexerTb;

    timeunit 1ns;
    timeprecision 1ps;

    import txMuxPkg::*;

    localparam int NUM_ENTRIES = 14;

    typedef struct packed {
        logic [2:0]             group;     // Entries of one group are raised together
        logic                   fair;
        logic                   stall;
        logic [`TXM_CHNL_W-1:0] chnl;
        logic                   isWr;
        logic [`TXM_ADDR_W-1:0] addr;
        logic [`TXM_LEN_W-1:0]  len;
        logic [`TXM_SG_W-1:0]   sg;
        logic [`TXM_TAG_W-1:0]  tag;
    } stimEntry_t;

    logic CLK = 1'b0;
    logic reset;
    logic [`TXM_NUM_CHNL-1:0] rdReq, wrReq, rdAck, wrAck, wrDataRen;
    rdReq_t [`TXM_NUM_CHNL-1:0] rdInfo;
    wrReq_t [`TXM_NUM_CHNL-1:0] wrInfo;
    logic [`TXM_NUM_CHNL-1:0][`TXM_DATA_W-1:0] wrData;
    logic [`TXM_SG_W+`TXM_CHNL_W-1:0] intTag;
    logic intTagValid, extTagValid, rdReqSent, rxBufSpaceAvail;
    logic metaValid, metaReady, dataValid;
    logic [`TXM_TAG_W-1:0] extTag;
    txMeta_t meta;
    dataBeat_t beat;

    stimEntry_t tbl [NUM_ENTRIES];
    int chanQ [`TXM_NUM_CHNL][$];           // Pending table entries per channel
    txMeta_t expMeta [$];
    logic [3:0] expBeat [$];                // Start, end, end offset
    logic [`TXM_DATA_W-1:0] expData [$];
    logic pendValid [`TXM_NUM_CHNL][`TXM_FIFO_LATENCY];
    logic [`TXM_DATA_W-1:0] pendWord [`TXM_NUM_CHNL][`TXM_FIFO_LATENCY];
    int ackCount [`TXM_NUM_CHNL];
    int metaSeen = 0;
    logic fairMode = 1'b0;
    integer seed = 32'h6a6a;

    txMultiplexer DUT (.*);

    always #20 CLK = ~CLK;

    task automatic reportFailure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [255:0] got,
                              input logic [255:0] exp);
        if (got !== exp) begin
            reportFailure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    initial begin
        tbl[0]  = '{3'd0, 1'b0, 1'b0, 2'd0, 1'b1, 32'h0000_1000, 10'd1,  2'd0, 5'h03};
        tbl[1]  = '{3'd1, 1'b0, 1'b0, 2'd1, 1'b0, 32'h0000_2000, 10'd8,  2'd2, 5'h07};
        tbl[2]  = '{3'd2, 1'b0, 1'b0, 2'd2, 1'b1, 32'h0000_3000, 10'd4,  2'd0, 5'h0a};
        tbl[3]  = '{3'd2, 1'b0, 1'b0, 2'd3, 1'b1, 32'h0000_3400, 10'd5,  2'd0, 5'h1b};
        tbl[4]  = '{3'd2, 1'b0, 1'b0, 2'd1, 1'b0, 32'h0000_3800, 10'd16, 2'd1, 5'h11};
        tbl[5]  = '{3'd3, 1'b1, 1'b0, 2'd0, 1'b1, 32'h0000_4000, 10'd13, 2'd0, 5'h01};
        tbl[6]  = '{3'd3, 1'b1, 1'b0, 2'd1, 1'b1, 32'h0000_4100, 10'd1,  2'd0, 5'h02};
        tbl[7]  = '{3'd3, 1'b1, 1'b0, 2'd2, 1'b1, 32'h0000_4200, 10'd4,  2'd0, 5'h14};
        tbl[8]  = '{3'd3, 1'b1, 1'b0, 2'd3, 1'b1, 32'h0000_4300, 10'd5,  2'd0, 5'h15};
        tbl[9]  = '{3'd3, 1'b1, 1'b0, 2'd0, 1'b1, 32'h0000_4400, 10'd2,  2'd0, 5'h06};
        tbl[10] = '{3'd3, 1'b1, 1'b0, 2'd1, 1'b1, 32'h0000_4500, 10'd3,  2'd0, 5'h17};
        tbl[11] = '{3'd3, 1'b1, 1'b0, 2'd2, 1'b1, 32'h0000_4600, 10'd8,  2'd0, 5'h08};
        tbl[12] = '{3'd3, 1'b1, 1'b0, 2'd3, 1'b1, 32'h0000_4700, 10'd13, 2'd0, 5'h19};
        tbl[13] = '{3'd4, 1'b0, 1'b1, 2'd3, 1'b1, 32'h0000_5000, 10'd13, 2'd0, 5'h0c};
    end

    // ------------------------------------------------------------
    // Channel side, tag exchange and FIFO model on the falling edge
    // ------------------------------------------------------------
    always @(negedge CLK) begin
        int e;
        int n;
        txMeta_t m;
        logic [`TXM_DATA_W-1:0] word;
        for (int c = 0; c < `TXM_NUM_CHNL; c++) begin
            if (!reset && (rdAck[c] || wrAck[c])) begin
                if (chanQ[c].size() == 0)
                    reportFailure("Acknowledge on a channel that has no request");
                e = chanQ[c][0];
                checkValue("wrAck", 256'(wrAck[c]), 256'(tbl[e].isWr));
                if (rdAck[c]) begin
                    // Values seen by the DUT on the edge that raised the acknowledge
                    checkValue("rdAck conditions", 256'({extTagValid, rxBufSpaceAvail}),
                               256'(2'b11));
                    checkValue("intTagValid", 256'(intTagValid), 256'(1'b1));
                    checkValue("rdReqSent", 256'(rdReqSent), 256'(1'b1));
                    checkValue("intTag", 256'(intTag), 256'({tbl[e].sg, c[1:0]}));
                end
                if (fairMode && wrAck[c]) begin
                    for (int d = 0; d < `TXM_NUM_CHNL; d++)
                        if (ackCount[c] > ackCount[d])
                            reportFailure("A channel was acknowledged twice before another");
                    ackCount[c]++;
                end
                extTag = tbl[e].tag;            // Answer sampled on the next rising edge
                m.reqType = tbl[e].isWr;
                m.addr    = tbl[e].addr;
                m.len     = tbl[e].len;
                m.tag     = tbl[e].tag ^ {tbl[e].isWr, 4'b0000};
                m.firstBe = 4'b1111;
                m.lastBe  = (tbl[e].len == 10'd1) ? 4'b0000 : 4'b1111;
                expMeta.push_back(m);
                if (tbl[e].isWr) begin
                    n = (int'(tbl[e].len) + 3) / 4;
                    for (int i = 0; i < n; i++)
                        expBeat.push_back({i == 0, i == n - 1,
                                           2'((int'(tbl[e].len) - 1) % 4)});
                end
                chanQ[c].pop_front();
            end
            // Channel word appears a fixed latency after each read enable
            if (pendValid[c][`TXM_FIFO_LATENCY-1])
                wrData[c] = pendWord[c][`TXM_FIFO_LATENCY-1];
            for (int k = `TXM_FIFO_LATENCY - 1; k > 0; k--) begin
                pendValid[c][k] = pendValid[c][k-1];
                pendWord[c][k]  = pendWord[c][k-1];
            end
            pendValid[c][0] = !reset && wrDataRen[c];
            if (!reset && wrDataRen[c]) begin
                word = {$random(seed), $random(seed), $random(seed), $random(seed)};
                pendWord[c][0] = word;
                expData.push_back(word);
            end
            e = (chanQ[c].size() != 0) ? chanQ[c][0] : 0;
            rdReq[c]  = (chanQ[c].size() != 0) && !tbl[e].isWr;
            wrReq[c]  = (chanQ[c].size() != 0) && tbl[e].isWr;
            rdInfo[c] = '{tbl[e].addr, tbl[e].len, tbl[e].sg};
            wrInfo[c] = '{tbl[e].addr, tbl[e].len};
        end
        extTagValid     = ($random(seed) & 3) != 0;   // Mostly available
        rxBufSpaceAvail = ($random(seed) & 3) != 0;
    end

    // Formatter side scoreboard
    always @(posedge CLK) begin
        if (!reset && metaValid) begin
            checkValue("metaReady", 256'(metaReady), 256'(1'b1));
            if (expMeta.size() == 0)
                reportFailure("Metadata word issued with no request acknowledged");
            checkValue("meta", 256'(meta), 256'(expMeta[0]));
            expMeta.pop_front();
            metaSeen++;
        end
        if (!reset && dataValid) begin
            if (expBeat.size() == 0 || expData.size() == 0)
                reportFailure("Data beat issued with no write beat expected");
            checkValue("beat.data", 256'(beat.data), 256'(expData[0]));
            checkValue("beat.flags", 256'({beat.startFlag, beat.endFlag, beat.endOffset}),
                       256'(expBeat[0]));
            expBeat.pop_front();
            expData.pop_front();
        end
    end

    initial begin
        repeat (NUM_ENTRIES * 200 + 1000) @(posedge CLK);
        reportFailure("Timeout: requests were not all served in time");
    end

    initial begin
        int e;
        int first;
        int target;
        reset = 1'b1;
        rdReq = '0;
        wrReq = '0;
        rdInfo = '0;
        wrInfo = '0;
        wrData = '0;
        extTag = '0;
        extTagValid = 1'b0;
        rxBufSpaceAvail = 1'b0;
        metaReady = 1'b1;
        for (int c = 0; c < `TXM_NUM_CHNL; c++)
            for (int k = 0; k < `TXM_FIFO_LATENCY; k++)
                pendValid[c][k] = 1'b0;
        repeat (16) @(posedge CLK);
        @(negedge CLK) reset = 1'b0;
        e = 0;
        while (e < NUM_ENTRIES) begin
            first  = e;
            target = metaSeen;
            @(posedge CLK);
            fairMode = tbl[first].fair;
            for (int c = 0; c < `TXM_NUM_CHNL; c++)
                ackCount[c] = 0;
            while (e < NUM_ENTRIES && tbl[e].group == tbl[first].group) begin
                chanQ[tbl[e].chnl].push_back(e);
                e++;
                target++;
            end
            if (tbl[first].stall) begin
                @(negedge CLK) metaReady = 1'b0;   // Formatter back-pressure
                repeat (40) @(negedge CLK);
                metaReady = 1'b1;
            end
            while (metaSeen < target) @(negedge CLK);
        end
        while (expBeat.size() != 0) @(negedge CLK);
        repeat (10) @(negedge CLK);
        if (expData.size() != 0) begin
            reportFailure("Read enables were issued for words that left in no beat");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/txMultiplexer_checker.sv
`default_nettype none

`include "txMux_defs.svh"

module txMultiplexerChecker (
    input  logic                        CLK,
    input  logic                        reset,
    input  logic [`TXM_NUM_CHNL-1:0]    rdAck,
    input  logic [`TXM_NUM_CHNL-1:0]    wrAck,
    input  logic                        metaValid,
    input  logic                        metaReady,
    input  logic                        intTagValid,
    input  logic                        rdReqSent
);

    timeunit 1ns;
    timeprecision 1ps;

    // Only one channel per side is acknowledged at a time
    rdAckOneHot: assert property (@(posedge CLK) disable iff (reset) $onehot0(rdAck))
        else $error("rdAck has more than one bit set");
    wrAckOneHot: assert property (@(posedge CLK) disable iff (reset) $onehot0(wrAck))
        else $error("wrAck has more than one bit set");

    metaHandshake: assert property (@(posedge CLK) disable iff (reset) metaValid |-> metaReady)
        else $error("metaValid raised while metaReady is low");

    // Tag exchange and read-sent pulse travel together
    tagWithSent: assert property (@(posedge CLK) disable iff (reset) intTagValid == rdReqSent)
        else $error("intTagValid and rdReqSent differ");

endmodule

bind txMultiplexer txMultiplexerChecker checker_i (.*);

`default_nettype wire
